/* l2_cache.f */
design/l2_cache_pkg.sv
design/l2_cache_control.sv
design/l2_cache_tag_array.sv
design/l2_cache_data_array.sv
design/l2_cache_plru.sv
design/l2_cache_ewb.sv
design/l2_cache.sv
verif/l2_cache_mem_model.sv
verif/l2_cache_tb.sv

/* verif/l2_cache_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l2 cache testbench with reference model and checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module l2_cache_tb;

    localparam int CLK_PERIOD = 4;
    localparam int TOTAL_REQS = 225;

    logic                clk_i, rst_i;
    l2_cache_pkg::addr_t mem_address, pmem_address;
    logic                mem_read, mem_write, mem_resp;
    logic                pmem_read, pmem_write, pmem_resp;
    l2_cache_pkg::line_t mem_wdata, mem_rdata, pmem_wdata, pmem_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    l2_cache_pkg::tag_t  m_tag   [8][4];
    l2_cache_pkg::line_t m_data  [8][4];
    logic [3:0]          m_valid [8];
    logic [3:0]          m_dirty [8];
    l2_cache_pkg::plru_t m_plru  [8];
    logic                m_ewb_full;
    l2_cache_pkg::addr_t m_ewb_addr;
    l2_cache_pkg::line_t m_ewb_line;
    l2_cache_pkg::line_t shadow     [1024];
    logic                shadow_set [1024];

    string               name_q[$];
    l2_cache_pkg::line_t exp_line_q[$], wb_line_q[$];
    l2_cache_pkg::addr_t wb_addr_q[$];
    logic                exp_miss_q[$], is_read_q[$];
    int                  lat_q[$], start_q[$];
    int                  cycle;
    logic                miss_seen;
    logic [31:0]         rng;

    l2_cache l2_cache_i (
        .clk_i, .rst_i, .mem_address_i(mem_address), .mem_read_i(mem_read),
        .mem_write_i(mem_write), .mem_wdata_i(mem_wdata), .mem_rdata_o(mem_rdata),
        .mem_resp_o(mem_resp), .pmem_address_o(pmem_address), .pmem_read_o(pmem_read),
        .pmem_write_o(pmem_write), .pmem_wdata_o(pmem_wdata), .pmem_rdata_i(pmem_rdata),
        .pmem_resp_i(pmem_resp)
    );

    l2_cache_mem_model mem_model_i (
        .clk_i, .rst_i, .address_i(pmem_address), .read_i(pmem_read), .write_i(pmem_write),
        .wdata_i(pmem_wdata), .rdata_o(pmem_rdata), .resp_o(pmem_resp)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic l2_cache_pkg::line_t mem_line(input l2_cache_pkg::addr_t a);
        l2_cache_pkg::line_t l;
        if (shadow_set[a[14:5]]) return shadow[a[14:5]];
        for (int k = 0; k < 8; k++) l[k*32 +: 32] = a ^ (32'h9e3779b9 * (k + 1));
        return l;
    endfunction

    function automatic l2_cache_pkg::way_t pick_victim(input l2_cache_pkg::index_t s);
        logic pair;
        l2_cache_pkg::way_t v;
        pair = m_plru[s][0];
        v    = {pair, pair ? m_plru[s][2] : m_plru[s][1]};
        for (int w = 3; w >= 0; w--) begin
            if (!m_valid[s][w]) v = l2_cache_pkg::way_t'(w);
        end
        return v;
    endfunction

    function automatic void touch(input l2_cache_pkg::index_t s, input l2_cache_pkg::way_t w);
        m_plru[s][0] = ~w[1];   // point at the other pair.
        if (w[1]) m_plru[s][2] = ~w[0];
        else      m_plru[s][1] = ~w[0];
    endfunction

    function automatic void write_back();
        wb_addr_q.push_back(m_ewb_addr);
        wb_line_q.push_back(m_ewb_line);
        shadow[m_ewb_addr[14:5]]     = m_ewb_line;
        shadow_set[m_ewb_addr[14:5]] = 1'b1;
        m_ewb_full = 1'b0;
    endfunction

    // advances the reference state by one request.
    function automatic l2_cache_pkg::line_t predict(input l2_cache_pkg::addr_t a,
            input logic wr, input l2_cache_pkg::line_t wd, output logic miss);
        l2_cache_pkg::index_t s;
        l2_cache_pkg::way_t   w;
        l2_cache_pkg::line_t  fill;
        l2_cache_pkg::addr_t  victim_a;
        logic                 hit, dirty, evict;
        s    = a[7:5];
        hit  = 1'b0;
        miss = 1'b0;
        w    = '0;
        for (int i = 0; i < 4; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == a[31:8]) begin
                hit = 1'b1;
                w   = l2_cache_pkg::way_t'(i);
            end
        end
        if (hit) begin
            if (wr) begin
                m_data[s][w]  = wd;
                m_dirty[s][w] = 1'b1;
            end
        end else begin
            w        = pick_victim(s);
            victim_a = {m_tag[s][w], s, 5'b0};
            evict    = m_valid[s][w] && m_dirty[s][w];
            if (m_ewb_full && m_ewb_addr == a) begin
                fill       = m_ewb_line;   // reinstated from the buffer.
                dirty      = 1'b1;
                m_ewb_full = 1'b0;
            end else begin
                miss  = 1'b1;
                fill  = mem_line(a);
                dirty = wr;
                if (evict && m_ewb_full) write_back();
            end
            if (evict) begin
                m_ewb_full = 1'b1;
                m_ewb_addr = victim_a;
                m_ewb_line = m_data[s][w];
            end
            if (wr) fill = wd;
            m_tag[s][w]   = a[31:8];
            m_valid[s][w] = 1'b1;
            m_dirty[s][w] = dirty;
            m_data[s][w]  = fill;
        end
        touch(s, w);
        return m_data[s][w];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_line(input string name, input l2_cache_pkg::line_t exp,
            input l2_cache_pkg::line_t act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_addr(input string name, input l2_cache_pkg::addr_t exp,
            input l2_cache_pkg::addr_t act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_miss(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s miss expected %b actual %b", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Mismatch %s latency expected %0d actual %0d", name, exp, act);
            report_failure();
        end
    endtask

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (mem_resp) begin
            if (name_q.size() == 0) begin
                $display("response arrived with no request outstanding");
                report_failure();
            end
            if (is_read_q[0]) check_line(name_q[0], exp_line_q[0], mem_rdata);
            check_miss(name_q[0], exp_miss_q[0], miss_seen);
            if (lat_q[0] >= 0) check_latency(name_q[0], lat_q[0], cycle - start_q[0]);
            void'(name_q.pop_front());
            void'(exp_line_q.pop_front());
            void'(exp_miss_q.pop_front());
            void'(is_read_q.pop_front());
            void'(lat_q.pop_front());
            void'(start_q.pop_front());
            miss_seen = 1'b0;
        end else if (pmem_read) begin
            miss_seen = 1'b1;
        end
        if (pmem_write && pmem_resp) begin
            if (wb_addr_q.size() == 0) begin
                $display("memory written at %h with no write-back due", pmem_address);
                report_failure();
            end
            check_addr("write-back address", wb_addr_q.pop_front(), pmem_address);
            check_line("write-back data", wb_line_q.pop_front(), pmem_wdata);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // called 1 ns after a rising edge, returns at the same point.
    task automatic issue_request(input string name, input l2_cache_pkg::addr_t a,
            input logic wr, input l2_cache_pkg::line_t wd, input int lat);
        logic miss;
        exp_line_q.push_back(predict(a, wr, wd, miss));
        exp_miss_q.push_back(miss);
        name_q.push_back(name);
        is_read_q.push_back(!wr);
        lat_q.push_back(lat);
        start_q.push_back(cycle);
        mem_address = a;
        mem_read    = !wr;
        mem_write   = wr;
        mem_wdata   = wd;
        do @(posedge clk_i); while (!mem_resp);
        #1;
    endtask

    function automatic l2_cache_pkg::line_t rand_line();
        l2_cache_pkg::line_t l;
        for (int k = 0; k < 8; k++) begin
            rng          = next_rand(rng);
            l[k*32 +: 32] = rng;
        end
        return l;
    endfunction

    function automatic l2_cache_pkg::addr_t line_addr(input int tag, input int set);
        return {l2_cache_pkg::tag_t'(tag), l2_cache_pkg::index_t'(set), 5'b0};
    endfunction

    initial begin
        #(TOTAL_REQS * 40 * CLK_PERIOD);
        $display("timeout: the cache stopped responding");
        report_failure();
    end

    initial begin
        int                   sets [3];
        l2_cache_pkg::line_t  wd;
        l2_cache_pkg::addr_t  addr;
        logic                 wr;
        rst_i       = 1'b1;
        mem_address = '0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_wdata   = '0;
        cycle       = 0;
        miss_seen   = 1'b0;
        rng         = 32'd9;
        sets        = '{0, 5, 6};
        m_ewb_full  = 1'b0;
        for (int s = 0; s < 8; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_plru[s]  = '0;
        end
        for (int i = 0; i < 1024; i++) shadow_set[i] = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        issue_request("cold read", line_addr(1, 1), 1'b0, '0, -1);
        issue_request("read hit", line_addr(1, 1), 1'b0, '0, 2);
        wd = rand_line();
        issue_request("write", line_addr(2, 2), 1'b1, wd, -1);
        issue_request("read after write", line_addr(2, 2), 1'b0, '0, -1);
        for (int t = 40; t < 44; t++) begin
            issue_request("evict written", line_addr(t, 2), 1'b0, '0, -1);
        end

        for (int t = 10; t < 14; t++) issue_request("plru fill", line_addr(t, 3), 1'b0, '0, -1);
        issue_request("plru touch", line_addr(10, 3), 1'b0, '0, -1);
        issue_request("plru evict", line_addr(14, 3), 1'b0, '0, -1);
        for (int t = 10; t < 14; t++) issue_request("plru probe", line_addr(t, 3), 1'b0, '0, -1);

        for (int t = 20; t < 26; t++) begin
            wd = rand_line();
            issue_request("dirty evict", line_addr(t, 4), 1'b1, wd, -1);
        end
        issue_request("buffer hit", m_ewb_addr, 1'b0, '0, -1);

        for (int n = 0; n < 200; n++) begin
            rng  = next_rand(rng);
            addr = line_addr(30 + (rng[15:4] % 6), sets[rng % 3]);
            wr   = rng[20];
            wd   = rand_line();
            issue_request("random", addr, wr, wd, -1);
        end
        mem_read  = 1'b0;
        mem_write = 1'b0;

        // an idle cache drains what is left in the buffer.
        if (m_ewb_full) write_back();
        while (wb_addr_q.size() != 0) @(posedge clk_i);
        repeat (2) @(posedge clk_i);
        if (pmem_read || pmem_write) begin
            $display("memory still requested after the buffer drained");
            report_failure();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/l2_cache_mem_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main memory model for the l2 cache testbench.
// line storage, response after 1 to 4 cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module l2_cache_mem_model (
    input  logic                clk_i,
    input  logic                rst_i,
    input  l2_cache_pkg::addr_t address_i,
    input  logic                read_i,
    input  logic                write_i,
    input  l2_cache_pkg::line_t wdata_i,
    output l2_cache_pkg::line_t rdata_o,
    output logic                resp_o
);

    l2_cache_pkg::line_t mem_q     [1024];   // indexed by address bits 14 to 5.
    logic                written_q [1024];
    logic [31:0]         rng_q;
    logic                busy_q;
    logic [1:0]          wait_q;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // untouched lines read back a pattern of their own address.
    function automatic l2_cache_pkg::line_t cold_line(input l2_cache_pkg::addr_t a);
        l2_cache_pkg::line_t l;
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = a ^ (32'h9e3779b9 * (k + 1));
        end
        return l;
    endfunction

    always @(posedge clk_i) begin
        resp_o <= 1'b0;
        if (rst_i) begin
            busy_q <= 1'b0;
            wait_q <= '0;
            rng_q  <= 32'd9;
            for (int i = 0; i < 1024; i++) written_q[i] <= 1'b0;
        end else if ((read_i || write_i) && !resp_o) begin
            if (!busy_q) begin
                busy_q <= 1'b1;
                wait_q <= rng_q[1:0];
                rng_q  <= next_rand(rng_q);
            end else if (wait_q != 0) begin
                wait_q <= wait_q - 1'b1;
            end else begin
                busy_q <= 1'b0;
                resp_o <= 1'b1;
                if (write_i) begin
                    mem_q[address_i[14:5]]     <= wdata_i;
                    written_q[address_i[14:5]] <= 1'b1;
                end else begin
                    rdata_o <= written_q[address_i[14:5]] ? mem_q[address_i[14:5]] :
                               cold_line(address_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/l2_cache.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l2 cache top, 4-way write-back with one eviction buffer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module l2_cache (
    input  logic                clk_i,
    input  logic                rst_i,
    // upstream side.
    input  l2_cache_pkg::addr_t mem_address_i,
    input  logic                mem_read_i,
    input  logic                mem_write_i,
    input  l2_cache_pkg::line_t mem_wdata_i,
    output l2_cache_pkg::line_t mem_rdata_o,
    output logic                mem_resp_o,
    // memory side.
    output l2_cache_pkg::addr_t pmem_address_o,
    output logic                pmem_read_o,
    output logic                pmem_write_o,
    output l2_cache_pkg::line_t pmem_wdata_o,
    input  l2_cache_pkg::line_t pmem_rdata_i,
    input  logic                pmem_resp_i
);

    logic                              hit, victim_valid, victim_dirty;
    logic                              ewb_full, ewb_match;
    logic                              tag_load, data_load, plru_load, set_dirty;
    logic                              fill_from_ewb, ewb_load, ewb_yumi;
    l2_cache_pkg::way_t                hit_way, victim_way, way_sel;
    l2_cache_pkg::tag_t                victim_tag;
    l2_cache_pkg::index_t              index;
    l2_cache_pkg::addr_t               victim_addr, ewb_addr;
    l2_cache_pkg::line_t               line, ewb_line;
    logic [l2_cache_pkg::NUM_WAYS-1:0] valid;

    assign index       = mem_address_i[l2_cache_pkg::LINE_OFFSET_W +: $bits(index)];
    assign victim_addr = {victim_tag, index, {l2_cache_pkg::LINE_OFFSET_W{1'b0}}};

    // write-back uses the buffered address.
    assign pmem_address_o = pmem_write_o ? ewb_addr : mem_address_i;
    assign pmem_wdata_o   = ewb_line;
    assign mem_rdata_o    = line;

    l2_cache_control control_i (
        .clk_i, .rst_i, .mem_read_i, .mem_write_i,
        .hit_i(hit), .hit_way_i(hit_way),
        .victim_valid_i(victim_valid), .victim_dirty_i(victim_dirty),
        .victim_way_i(victim_way), .ewb_full_i(ewb_full), .ewb_match_i(ewb_match),
        .pmem_resp_i, .mem_resp_o, .pmem_read_o, .pmem_write_o,
        .tag_load_o(tag_load), .data_load_o(data_load), .fill_from_ewb_o(fill_from_ewb),
        .plru_load_o(plru_load), .ewb_load_o(ewb_load), .ewb_yumi_o(ewb_yumi),
        .set_dirty_o(set_dirty), .way_sel_o(way_sel)
    );

    l2_cache_tag_array tag_array_i (
        .clk_i, .rst_i, .load_i(tag_load), .set_dirty_i(set_dirty),
        .addr_i(mem_address_i), .way_i(way_sel), .victim_way_i(victim_way),
        .hit_o(hit), .hit_way_o(hit_way), .victim_valid_o(victim_valid),
        .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag), .valid_o(valid)
    );

    l2_cache_data_array data_array_i (
        .clk_i, .load_i(data_load), .use_ewb_i(fill_from_ewb), .index_i(index),
        .way_i(way_sel), .mem_wdata_i, .pmem_rdata_i, .ewb_rdata_i(ewb_line),
        .write_hit_i(mem_write_i), .line_o(line)
    );

    l2_cache_plru plru_i (
        .clk_i, .rst_i, .load_i(plru_load), .index_i(index), .way_i(way_sel),
        .valid_i(valid), .victim_o(victim_way)
    );

    l2_cache_ewb ewb_i (
        .clk_i, .rst_i, .load_i(ewb_load), .yumi_i(ewb_yumi), .line_i(line),
        .addr_i(victim_addr), .match_addr_i(mem_address_i), .full_o(ewb_full),
        .match_o(ewb_match), .line_o(ewb_line), .addr_o(ewb_addr)
    );

endmodule

`default_nettype wire

/* design/l2_cache_ewb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l2 cache eviction write buffer.
// one dirty victim line, matched against the pending request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module l2_cache_ewb (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                load_i,
    input  logic                yumi_i,
    input  l2_cache_pkg::line_t line_i,
    input  l2_cache_pkg::addr_t addr_i,
    input  l2_cache_pkg::addr_t match_addr_i,
    output logic                full_o,
    output logic                match_o,
    output l2_cache_pkg::line_t line_o,
    output l2_cache_pkg::addr_t addr_o
);

    logic                full_q;
    l2_cache_pkg::line_t line_q;
    l2_cache_pkg::addr_t addr_q;

    // load beats yumi, so a swap keeps the entry full.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full_q <= 1'b0;
        end else if (load_i) begin
            full_q <= 1'b1;
        end else if (yumi_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            line_q <= line_i;
            addr_q <= addr_i;
        end
    end

    assign full_o  = full_q;
    // line compare.
    assign match_o = full_q && ((addr_q >> l2_cache_pkg::LINE_OFFSET_W) ==
                                (match_addr_i >> l2_cache_pkg::LINE_OFFSET_W));
    assign line_o  = line_q;
    assign addr_o  = addr_q;

endmodule

`default_nettype wire

/* design/l2_cache_plru.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l2 cache tree pseudo-LRU, one 3 bit tree per set.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module l2_cache_plru (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              load_i,
    input  l2_cache_pkg::index_t              index_i,
    input  l2_cache_pkg::way_t                way_i,
    input  logic [l2_cache_pkg::NUM_WAYS-1:0] valid_i,
    output l2_cache_pkg::way_t                victim_o
);

    l2_cache_pkg::plru_t bits_q [l2_cache_pkg::NUM_SETS];
    l2_cache_pkg::plru_t cur;
    l2_cache_pkg::plru_t nxt;

    assign cur = bits_q[index_i];

    // point the path away from the accessed way.
    always_comb begin
        nxt = cur;
        if (way_i[1] == 1'b0) begin
            nxt[0] = 1'b1;
            nxt[1] = ~way_i[0];
        end else begin
            nxt[0] = 1'b0;
            nxt[2] = ~way_i[0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < l2_cache_pkg::NUM_SETS; s++) bits_q[s] <= '0;
        end else if (load_i) begin
            bits_q[index_i] <= nxt;
        end
    end

    // lowest invalid way first, else follow the tree.
    always_comb begin
        victim_o = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
        for (int w = l2_cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_i[w]) victim_o = l2_cache_pkg::way_t'(w);
        end
    end

endmodule

`default_nettype wire

/* design/l2_cache_data_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l2 cache line store with fill source select.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module l2_cache_data_array (
    input  logic                 clk_i,
    input  logic                 load_i,
    input  logic                 use_ewb_i,
    input  l2_cache_pkg::index_t index_i,
    input  l2_cache_pkg::way_t   way_i,
    input  l2_cache_pkg::line_t  mem_wdata_i,
    input  l2_cache_pkg::line_t  pmem_rdata_i,
    input  l2_cache_pkg::line_t  ewb_rdata_i,
    input  logic                 write_hit_i,
    output l2_cache_pkg::line_t  line_o
);

    l2_cache_pkg::line_t lines_q [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS];
    l2_cache_pkg::line_t fill_line;

    // upstream data always wins on a write.
    always_comb begin
        if (write_hit_i)    fill_line = mem_wdata_i;
        else if (use_ewb_i) fill_line = ewb_rdata_i;
        else                fill_line = pmem_rdata_i;
    end

    always_ff @(posedge clk_i) begin
        if (load_i) lines_q[index_i][way_i] <= fill_line;
    end

    assign line_o = lines_q[index_i][way_i];

endmodule

`default_nettype wire

/* design/l2_cache_tag_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l2 cache tag store.
// tag, valid and dirty per way, hit and victim lookup.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module l2_cache_tag_array (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                load_i,
    input  logic                                set_dirty_i,
    input  l2_cache_pkg::addr_t                 addr_i,
    input  l2_cache_pkg::way_t                  way_i,
    input  l2_cache_pkg::way_t                  victim_way_i,
    output logic                                hit_o,
    output l2_cache_pkg::way_t                  hit_way_o,
    output logic                                victim_valid_o,
    output logic                                victim_dirty_o,
    output l2_cache_pkg::tag_t                  victim_tag_o,
    output logic [l2_cache_pkg::NUM_WAYS-1:0]   valid_o
);

    l2_cache_pkg::tag_t                tags_q  [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS];
    logic [l2_cache_pkg::NUM_WAYS-1:0] valid_q [l2_cache_pkg::NUM_SETS];
    logic [l2_cache_pkg::NUM_WAYS-1:0] dirty_q [l2_cache_pkg::NUM_SETS];
    l2_cache_pkg::index_t              index;
    l2_cache_pkg::tag_t                tag;
    logic [l2_cache_pkg::NUM_WAYS-1:0] way_hits;

    assign index = addr_i[l2_cache_pkg::LINE_OFFSET_W +: $bits(l2_cache_pkg::index_t)];
    assign tag   = addr_i[$bits(l2_cache_pkg::addr_t)-1 -: $bits(l2_cache_pkg::tag_t)];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < l2_cache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (load_i) begin
            valid_q[index][way_i] <= 1'b1;
            dirty_q[index][way_i] <= set_dirty_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) tags_q[index][way_i] <= tag;
    end

    // compare all ways of the set.
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++) begin
            way_hits[w] = valid_q[index][w] && (tags_q[index][w] == tag);
            if (way_hits[w]) hit_way_o = l2_cache_pkg::way_t'(w);
        end
    end

    assign hit_o          = |way_hits;
    assign valid_o        = valid_q[index];
    assign victim_valid_o = valid_q[index][victim_way_i];
    assign victim_dirty_o = dirty_q[index][victim_way_i];
    assign victim_tag_o   = tags_q[index][victim_way_i];   // for the eviction address.

endmodule

`default_nettype wire

/* design/l2_cache_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l2 cache controller.
// sequences lookup, eviction, refill and buffer drain.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/100ps

module l2_cache_control (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               mem_read_i,
    input  logic               mem_write_i,
    input  logic               hit_i,
    input  l2_cache_pkg::way_t hit_way_i,
    input  logic               victim_valid_i,
    input  logic               victim_dirty_i,
    input  l2_cache_pkg::way_t victim_way_i,
    input  logic               ewb_full_i,
    input  logic               ewb_match_i,
    input  logic               pmem_resp_i,
    output logic               mem_resp_o,
    output logic               pmem_read_o,
    output logic               pmem_write_o,
    output logic               tag_load_o,
    output logic               data_load_o,
    output logic               fill_from_ewb_o,
    output logic               plru_load_o,
    output logic               ewb_load_o,
    output logic               ewb_yumi_o,
    output logic               set_dirty_o,
    output l2_cache_pkg::way_t way_sel_o
);

    l2_cache_pkg::ctrl_state_t state_q;
    l2_cache_pkg::ctrl_state_t state_d;
    l2_cache_pkg::way_t        way_q;
    logic                      miss_q;   // drain was entered from a miss.
    logic                      req;
    logic                      evict_needed;

    assign req          = mem_read_i | mem_write_i;
    assign evict_needed = victim_valid_i & victim_dirty_i;
    assign set_dirty_o  = mem_write_i | fill_from_ewb_o;

    // the way is live during lookup, held afterwards.
    assign way_sel_o = (state_q == l2_cache_pkg::S_LOOKUP) ?
                       (hit_i ? hit_way_i : victim_way_i) : way_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= l2_cache_pkg::S_IDLE;
            way_q   <= '0;
            miss_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == l2_cache_pkg::S_LOOKUP) begin
                way_q  <= way_sel_o;
                miss_q <= ~hit_i;
            end else if (state_q == l2_cache_pkg::S_IDLE) begin
                miss_q <= 1'b0;   // idle drain.
            end
        end
    end

    always_comb begin
        state_d         = state_q;
        mem_resp_o      = 1'b0;
        pmem_read_o     = 1'b0;
        pmem_write_o    = 1'b0;
        tag_load_o      = 1'b0;
        data_load_o     = 1'b0;
        fill_from_ewb_o = 1'b0;
        plru_load_o     = 1'b0;
        ewb_load_o      = 1'b0;
        ewb_yumi_o      = 1'b0;
        case (state_q)
            l2_cache_pkg::S_IDLE: begin
                if (req) begin
                    state_d = l2_cache_pkg::S_LOOKUP;
                end else if (ewb_full_i) begin
                    state_d = l2_cache_pkg::S_DRAIN;
                end
            end
            l2_cache_pkg::S_LOOKUP: begin
                if (hit_i) begin
                    plru_load_o = 1'b1;
                    tag_load_o  = mem_write_i;   // marks the line dirty.
                    data_load_o = mem_write_i;
                    state_d     = l2_cache_pkg::S_RESP;
                end else if (ewb_match_i) begin
                    state_d = l2_cache_pkg::S_FILL;   // swap with the buffer.
                end else if (evict_needed) begin
                    state_d = ewb_full_i ? l2_cache_pkg::S_DRAIN : l2_cache_pkg::S_EVICT;
                end else begin
                    state_d = l2_cache_pkg::S_FILL;
                end
            end
            l2_cache_pkg::S_DRAIN: begin
                pmem_write_o = 1'b1;
                if (pmem_resp_i) begin
                    ewb_yumi_o = 1'b1;
                    state_d    = miss_q ? l2_cache_pkg::S_EVICT : l2_cache_pkg::S_IDLE;
                end
            end
            l2_cache_pkg::S_EVICT: begin
                ewb_load_o = 1'b1;
                state_d    = l2_cache_pkg::S_FILL;
            end
            l2_cache_pkg::S_FILL: begin
                if (ewb_match_i) begin
                    // buffered line comes back, a dirty victim takes its slot.
                    fill_from_ewb_o = 1'b1;
                    ewb_yumi_o      = 1'b1;
                    ewb_load_o      = evict_needed;
                    tag_load_o      = 1'b1;
                    data_load_o     = 1'b1;
                    plru_load_o     = 1'b1;
                    state_d         = l2_cache_pkg::S_RESP;
                end else begin
                    pmem_read_o = 1'b1;
                    if (pmem_resp_i) begin
                        tag_load_o  = 1'b1;
                        data_load_o = 1'b1;
                        plru_load_o = 1'b1;
                        state_d     = l2_cache_pkg::S_RESP;
                    end
                end
            end
            l2_cache_pkg::S_RESP: begin
                mem_resp_o = 1'b1;
                state_d    = l2_cache_pkg::S_IDLE;
            end
            default: state_d = l2_cache_pkg::S_IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* design/l2_cache_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l2 cache shared definitions.
// widths, geometry and controller states.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package l2_cache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int LINE_OFFSET_W = 5;   // 32 byte lines.
    localparam int NUM_SETS      = 8;
    localparam int NUM_WAYS      = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0]  addr_t;      // byte address.
    typedef logic [255:0] line_t;      // one full line.
    typedef logic [23:0]  tag_t;       // address bits 31 to 8.
    typedef logic [2:0]   index_t;     // address bits 7 to 5.
    typedef logic [1:0]   way_t;
    typedef logic [2:0]   plru_t;      // tree bits of one set.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        S_IDLE,     // waiting for a request.
        S_LOOKUP,   // tag compare.
        S_EVICT,    // victim into the buffer.
        S_DRAIN,    // buffer write-back.
        S_FILL,     // refill read.
        S_RESP      // respond upstream.
    } ctrl_state_t;

endpackage

`default_nettype wire
